// ==== Makefile ====
TOP  := timed_sequencer_tb
SRCS := $(filter-out +%,$(shell cat timed_sequencer.f)) common/seq_macros.svh

.PHONY: run clean

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

obj_dir/V$(TOP): $(SRCS) timed_sequencer.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f timed_sequencer.f --top-module $(TOP) -o V$(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== bench/timed_sequencer_tb.sv ====
`timescale 1ns/1ps
`include "seq_macros.svh"

module timed_sequencer_tb;

	import seq_pkg::*;

	localparam int DEPTH     = 1 << `SEQ_FIFO_DEPTH_LOG2;
	localparam int MAX_OFS   = 16;  // random due offsets are 4 bits
	localparam int BURST_OFS = 40;
	// each test's commands times (largest offset + 3) plus a margin
	localparam int CYCLE_LIMIT = 4 * (MAX_OFS + 3) + 24 * (MAX_OFS + 3)
		+ 7 * (BURST_OFS + 3) + 3 * (MAX_OFS + 3) + 9 * (MAX_OFS + 3) + 800;

	logic                   clk;
	logic                   rst;
	logic                   host_wr;
	load_field_e            host_sel;
	logic [31:0]            host_word;
	logic                   start;
	logic                   stop;
	logic                   overflow;
	logic [`SEQ_TIME_W-1:0] current_time;
	bus_req_t               bus_req;
	logic                   bus_en;
	logic                   bus_wr;

	// reference model
	sched_cmd_t             exp_q[$];     // accepted but not yet issued
	sched_cmd_t             head;
	logic                   head_valid;
	bus_req_t               head_req;
	logic                   head_due;
	logic [`SEQ_TIME_W-1:0] exp_time;
	logic [`SEQ_TIME_W-1:0] prev_time;
	logic                   timer_on;     // follows the start and stop pulses
	logic                   started;
	logic                   exp_ovf;
	logic                   dropped;      // commit in flight will be lost
	int                     late_cycles;
	int                     gap_cycles;

	logic [31:0]            lfsr_q;
	logic [15:0]            last_addr;
	logic                   addr_known;
	logic [31:0]            burst_due;
	int                     errors;
	int                     tests_run;
	int                     tests_failed;
	int                     cycle_count;
	int                     mark;
	int                     i;

	timed_sequencer u_dut (
		.clk          (clk),
		.rst          (rst),
		.host_wr      (host_wr),
		.host_sel     (host_sel),
		.host_word    (host_word),
		.overflow     (overflow),
		.start        (start),
		.stop         (stop),
		.current_time (current_time),
		.bus_req      (bus_req),
		.bus_en       (bus_en),
		.bus_wr       (bus_wr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          k;
		v = '0;
		for (k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
		return v;
	endfunction

	// about half of these are already past due
	function automatic logic [31:0] rand_due();
		logic [31:0] base;
		base = (current_time > 8) ? current_time - 8 : '0;
		return base + rand_bits(4);
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("mismatch at %0t: %s", $time, msg);
	endtask

	// entered and left on a falling edge
	task automatic host_write(input load_field_e sel, input logic [31:0] word);
		host_wr   = 1'b1;
		host_sel  = sel;
		host_word = word;
		@(negedge clk);
		host_wr = 1'b0;
	endtask

	task automatic load_cmd(input logic [31:0] due, input bit wait_room);
		sched_cmd_t  c;
		logic [31:0] r;
		while (wait_room && exp_q.size() >= DEPTH) @(negedge clk);
		r          = rand_bits(32);
		c.due_time = due;
		c.data     = rand_bits(32);
		host_write(FIELD_TIME, due);
		// address is sometimes left over from the last command
		if (!addr_known || r[16]) begin
			last_addr  = r[15:0];
			addr_known = 1'b1;
			host_write(FIELD_ADDR, r);
		end
		c.addr = last_addr;
		host_write(FIELD_DATA, c.data);
		if (exp_q.size() < DEPTH) begin
			exp_q.push_back(c);
		end else begin
			dropped = 1'b1;
		end
		host_write(FIELD_COMMIT, rand_bits(32));
		dropped = 1'b0;
	endtask

	task automatic apply_reset();
		rst      = 1'b1;
		timer_on = 1'b0;
		exp_q.delete();
		repeat (4) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic pulse_start();
		start    = 1'b1;
		timer_on = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic pulse_stop();
		stop     = 1'b1;
		timer_on = 1'b0;
		@(negedge clk);
		stop = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0) @(negedge clk);
		repeat (6) @(negedge clk);  // room for a stray issue
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	assign head_req = {head.addr, head.data};
	assign head_due = head_valid && (current_time >= head.due_time) && (prev_time != '0);

	always @(posedge clk) begin
		if (rst) begin
			exp_time    <= '0;
			prev_time   <= '0;
			started     <= 1'b0;
			exp_ovf     <= 1'b0;
			late_cycles <= 0;
			gap_cycles  <= 3;
		end else begin
			if (bus_en && exp_q.size() != 0) void'(exp_q.pop_front());
			late_cycles <= (head_due && !bus_en) ? late_cycles + 1 : 0;
			gap_cycles  <= bus_en ? 0 : ((gap_cycles < 3) ? gap_cycles + 1 : 3);
			// one count per edge while the timer runs
			if (timer_on) exp_time <= exp_time + 1'b1;
			prev_time <= current_time;
			if (start) started <= 1'b1;
			if (dropped) exp_ovf <= 1'b1;
		end
		head_valid <= (exp_q.size() != 0);
		if (exp_q.size() != 0) head <= exp_q[0];
	end

	assert property (@(posedge clk)
		rst |-> (!bus_en && !bus_wr && !overflow && current_time == '0))
		else report_mismatch("outputs not cleared during reset");
	assert property (@(posedge clk) disable iff (rst) !started |-> !bus_en)
		else report_mismatch("bus write before timer start");
	assert property (@(posedge clk) disable iff (rst) bus_en == bus_wr)
		else report_mismatch("bus_en and bus_wr differ");
	assert property (@(posedge clk) disable iff (rst)
		bus_en |-> (head_valid && bus_req == head_req))
		else report_mismatch("bus payload or order wrong");
	assert property (@(posedge clk) disable iff (rst)
		bus_en |-> (current_time >= head.due_time))
		else report_mismatch("command issued before due time");
	assert property (@(posedge clk) disable iff (rst) late_cycles <= 2)
		else report_mismatch("due command not issued within 3 cycles");
	assert property (@(posedge clk) disable iff (rst) bus_en |-> (gap_cycles >= 2))
		else report_mismatch("issues closer than 3 cycles");
	assert property (@(posedge clk) disable iff (rst) current_time == exp_time)
		else report_mismatch("current_time off expected count");
	assert property (@(posedge clk) disable iff (rst) overflow == exp_ovf)
		else report_mismatch("overflow flag wrong");

	initial begin
		lfsr_q       = 32'h4e5cf4b3;
		host_wr      = 1'b0;
		host_sel     = FIELD_TIME;
		host_word    = '0;
		start        = 1'b0;
		stop         = 1'b0;
		dropped      = 1'b0;
		addr_known   = 1'b0;
		last_addr    = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		apply_reset();

		// commands sit in the fifo while time is still zero
		mark = errors;
		for (i = 0; i < 4; i++) load_cmd(rand_due(), 1'b1);
		repeat (20) @(negedge clk);
		pulse_start();
		drain();
		end_test("reset_state", mark);

		mark = errors;
		for (i = 0; i < 24; i++) begin
			load_cmd(rand_due(), 1'b1);
			repeat (rand_bits(2)) @(negedge clk);
		end
		drain();
		end_test("order_payload", mark);

		// all fall due together, then go out back to back
		mark = errors;
		burst_due = current_time + BURST_OFS;
		for (i = 0; i < 7; i++) load_cmd(burst_due, 1'b1);
		drain();
		end_test("due_burst", mark);

		mark = errors;
		for (i = 0; i < 3; i++) load_cmd(rand_due(), 1'b1);
		drain();
		pulse_stop();
		repeat (10) @(negedge clk);
		pulse_start();
		repeat (5) @(negedge clk);
		end_test("timer_hold", mark);

		// timer never started so the ninth commit is dropped
		mark = errors;
		apply_reset();
		for (i = 0; i < DEPTH + 1; i++) load_cmd(rand_bits(4), 1'b0);
		repeat (5) @(negedge clk);
		assert (overflow) else report_mismatch("overflow low after 9 commits");
		pulse_start();
		drain();
		apply_reset();  // only reset clears overflow
		end_test("overflow", mark);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== common/seq_macros.svh ====
`ifndef SEQ_MACROS_SVH
`define SEQ_MACROS_SVH

// command fifo depth as a power of two
// 3 gives 8 entries
`define SEQ_FIFO_DEPTH_LOG2 3

// width of the run timer and of the command time field
// the host loads time as one 32-bit word
`define SEQ_TIME_W 32

// bus payload widths
`define SEQ_ADDR_W 16
`define SEQ_DATA_W 32

`endif

// ==== common/seq_pkg.sv ====
`include "seq_macros.svh"

package seq_pkg;

	// one queued command, as the host loads it
	// due_time sits in the top bits, data in the bottom
	typedef struct packed {
		logic [`SEQ_TIME_W-1:0] due_time;  // issue when timer reaches this
		logic [`SEQ_ADDR_W-1:0] addr;      // register bus address
		logic [`SEQ_DATA_W-1:0] data;      // register bus write data
	} sched_cmd_t;

	// what goes out on the register bus in the issue cycle
	typedef struct packed {
		logic [`SEQ_ADDR_W-1:0] addr;
		logic [`SEQ_DATA_W-1:0] data;
	} bus_req_t;

	// host write selector
	typedef enum logic [1:0] {
		FIELD_TIME   = 2'd0,
		FIELD_ADDR   = 2'd1,
		FIELD_DATA   = 2'd2,
		FIELD_COMMIT = 2'd3   // push working command
	} load_field_e;

	// scheduler control states
	typedef enum logic [1:0] {
		IDLE      = 2'd0,  // timer not started yet
		FETCH     = 2'd1,  // pop next command
		FIFO_WAIT = 2'd2,  // fifo read data arriving
		EXEC      = 2'd3   // hold until due
	} sched_state_e;

endpackage

// ==== scheduler/cmd_scheduler.sv ====
`timescale 1ns/1ps
`include "seq_macros.svh"

module cmd_scheduler (
	input  logic                   clk,
	input  logic                   rst,

	// run timer, zero means not started
	input  logic [`SEQ_TIME_W-1:0] current_time,

	// command fifo
	input  seq_pkg::sched_cmd_t    pop_cmd,
	input  logic                   pop_valid,
	input  logic                   empty,
	output logic                   pop,

	// external register bus, write only
	output seq_pkg::bus_req_t      bus_req,
	output logic                   bus_en,
	output logic                   bus_wr
);

	import seq_pkg::*;

	sched_state_e state;
	sched_state_e next_state;
	sched_cmd_t   cmd_q;       // command waiting for its time
	logic         load_cmd;
	logic         clear_cmd;
	logic         time_started;
	logic         is_due;

	assign time_started = (current_time != '0);
	assign is_due       = (current_time >= cmd_q.due_time);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// outputs come straight from state, not registered
	always_comb begin
		next_state = state;
		pop        = 1'b0;
		load_cmd   = 1'b0;
		clear_cmd  = 1'b0;
		bus_en     = 1'b0;
		bus_wr     = 1'b0;
		case (state)
			IDLE: begin
				if (time_started) next_state = FETCH;
			end
			FETCH: begin
				// nothing to do until a command is queued
				if (!empty && time_started) begin
					pop        = 1'b1;
					next_state = FIFO_WAIT;
				end
			end
			FIFO_WAIT: begin
				load_cmd   = 1'b1;  // fifo data lands this cycle
				next_state = EXEC;
			end
			EXEC: begin
				if (is_due) begin
					bus_en     = 1'b1;
					bus_wr     = 1'b1;
					clear_cmd  = 1'b1;
					next_state = FETCH;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	// held command
	always_ff @(posedge clk) begin
		if (clear_cmd) begin
			cmd_q <= '0;
		end else if (load_cmd && pop_valid) begin
			cmd_q <= pop_cmd;
		end
	end

	assign bus_req.addr = cmd_q.addr;
	assign bus_req.data = cmd_q.data;

endmodule

// ==== src/cmd_fifo.sv ====
`timescale 1ns/1ps
`include "seq_macros.svh"

module cmd_fifo (
	input  logic                clk,
	input  logic                rst,

	// write side
	input  logic                push,
	input  seq_pkg::sched_cmd_t push_cmd,

	// read side, data one cycle after pop
	input  logic                pop,
	output seq_pkg::sched_cmd_t pop_cmd,
	output logic                pop_valid,

	output logic                empty,
	output logic                full
);

	import seq_pkg::*;

	localparam int AW    = `SEQ_FIFO_DEPTH_LOG2;
	localparam int DEPTH = 1 << AW;

	sched_cmd_t      mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [AW:0]     count;      // one extra bit to tell full from empty
	logic            do_wr;
	logic            do_rd;

	assign empty = (count == '0);
	assign full  = (count == DEPTH[AW:0]);

	// ignore pushes when full and pops when empty
	assign do_wr = push && !full;
	assign do_rd = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= push_cmd;
		end
		if (do_rd) begin
			pop_cmd <= mem[rd_ptr];
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= do_rd;
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

endmodule

// ==== src/cmd_loader.sv ====
`timescale 1ns/1ps

module cmd_loader (
	input  logic                 clk,
	input  logic                 rst,

	// host field writes
	input  logic                 host_wr,
	input  seq_pkg::load_field_e host_sel,
	input  logic [31:0]          host_word,

	// to command fifo
	input  logic                 full,
	output logic                 push,
	output seq_pkg::sched_cmd_t  push_cmd,

	output logic                 overflow
);

	import seq_pkg::*;

	sched_cmd_t work_cmd;    // command being assembled
	logic       commit;
	logic       overflow_q;

	assign commit = host_wr && (host_sel == FIELD_COMMIT);

	// fields are kept between commands, so the host
	// only rewrites what changes
	always_ff @(posedge clk) begin
		if (host_wr) begin
			case (host_sel)
				FIELD_TIME: work_cmd.due_time <= host_word;
				FIELD_ADDR: work_cmd.addr     <= host_word[15:0];  // upper half ignored
				FIELD_DATA: work_cmd.data     <= host_word;
				default: ;  // commit leaves fields alone
			endcase
		end
	end

	// push straight through in the commit cycle
	assign push     = commit && !full;
	assign push_cmd = work_cmd;

	// sticky, a dropped command is lost for good
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			overflow_q <= 1'b0;
		end else if (commit && full) begin
			overflow_q <= 1'b1;
		end
	end

	assign overflow = overflow_q;

endmodule

// ==== src/run_timer.sv ====
`timescale 1ns/1ps
`include "seq_macros.svh"

module run_timer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic                   stop,
	output logic [`SEQ_TIME_W-1:0] current_time
);

	logic running;
	logic run_next;

	// stop wins if both pulse together
	assign run_next = (running || start) && !stop;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			running <= 1'b0;
		end else begin
			running <= run_next;
		end
	end

	// count already steps on the start edge, so it reads 1 right after
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			current_time <= '0;
		end else if (run_next) begin
			current_time <= current_time + 1'b1;
		end
	end

endmodule

// ==== src/timed_sequencer.sv ====
`timescale 1ns/1ps
`include "seq_macros.svh"

module timed_sequencer (
	input  logic                   clk,
	input  logic                   rst,

	// host loading port
	input  logic                   host_wr,
	input  seq_pkg::load_field_e   host_sel,
	input  logic [31:0]            host_word,
	output logic                   overflow,

	// timer control
	input  logic                   start,
	input  logic                   stop,
	output logic [`SEQ_TIME_W-1:0] current_time,

	// register bus
	output seq_pkg::bus_req_t      bus_req,
	output logic                   bus_en,
	output logic                   bus_wr
);

	import seq_pkg::*;

	logic       push;
	sched_cmd_t push_cmd;
	logic       pop;
	sched_cmd_t pop_cmd;
	logic       pop_valid;
	logic       empty;
	logic       full;

	cmd_loader u_loader (
		.clk       (clk),
		.rst       (rst),
		.host_wr   (host_wr),
		.host_sel  (host_sel),
		.host_word (host_word),
		.full      (full),
		.push      (push),
		.push_cmd  (push_cmd),
		.overflow  (overflow)
	);

	cmd_fifo u_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (push),
		.push_cmd  (push_cmd),
		.pop       (pop),
		.pop_cmd   (pop_cmd),
		.pop_valid (pop_valid),
		.empty     (empty),
		.full      (full)
	);

	run_timer u_timer (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.stop         (stop),
		.current_time (current_time)
	);

	cmd_scheduler u_sched (
		.clk          (clk),
		.rst          (rst),
		.current_time (current_time),
		.pop_cmd      (pop_cmd),
		.pop_valid    (pop_valid),
		.empty        (empty),
		.pop          (pop),
		.bus_req      (bus_req),
		.bus_en       (bus_en),
		.bus_wr       (bus_wr)
	);

endmodule

// ==== timed_sequencer.f ====
+incdir+common
common/seq_pkg.sv
src/cmd_loader.sv
src/cmd_fifo.sv
src/run_timer.sv
scheduler/cmd_scheduler.sv
src/timed_sequencer.sv
bench/timed_sequencer_tb.sv
